// ==== hdl/dft_pkg.sv ====
//--------------------------------------------------------------------------
// shared widths, types and the twiddle ROM for the single-RAM radix-2 DFT
// engine; imported by every RTL block and by the reference model
//--------------------------------------------------------------------------
package dft_pkg;

	// largest packet is 2^LOG_N_MAX points
	localparam int LOG_N_MAX = 5;
	localparam int N_MAX = 1 << LOG_N_MAX;

	// one real or imaginary part, signed
	localparam int D_W = 16;

	// RAM word and butterfly operand
	typedef struct packed {
		logic signed [D_W-1:0] re;
		logic signed [D_W-1:0] im;
	} sample_t;

	// top sequencer phase, also selects the RAM owner
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_SINK,
		PH_STAGE,
		PH_SOURCE
	} phase_e;

	// W^k = cos(2*pi*k/N_MAX) - j*sin(2*pi*k/N_MAX), Q1.15
	// re holds the cosine, im the negative sine
	localparam sample_t TWIDDLE [N_MAX/2] = '{
		'{16'sd32767, 16'sd0},
		'{16'sd32138, -16'sd6393},
		'{16'sd30274, -16'sd12540},
		'{16'sd27246, -16'sd18205},
		'{16'sd23170, -16'sd23170},
		'{16'sd18205, -16'sd27246},
		'{16'sd12540, -16'sd30274},
		'{16'sd6393, -16'sd32138},
		'{16'sd0, -16'sd32767},
		'{-16'sd6393, -16'sd32138},
		'{-16'sd12540, -16'sd30274},
		'{-16'sd18205, -16'sd27246},
		'{-16'sd23170, -16'sd23170},
		'{-16'sd27246, -16'sd18205},
		'{-16'sd30274, -16'sd12540},
		'{-16'sd32138, -16'sd6393}
	};

endpackage

// ==== hdl/dft_mem_if.sv ====
//--------------------------------------------------------------------------
// access port of the shared sample RAM; clients drive the strobes, the
// RAM side returns read data one cycle after rd_en
//--------------------------------------------------------------------------
`timescale 1ns/1ps

interface dft_mem_if
	import dft_pkg::*;
();

	// write port, takes effect at the edge where wr_en is high
	logic                 wr_en;
	logic [LOG_N_MAX-1:0] wr_addr;
	sample_t              wr_data;

	// read port, one cycle latency
	logic                 rd_en;
	logic [LOG_N_MAX-1:0] rd_addr;
	sample_t              rd_data;

	modport client (output wr_en, wr_addr, wr_data, rd_en, rd_addr, input rd_data);
	modport ram (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);

endinterface

// ==== hdl/dft_ram.sv ====
//--------------------------------------------------------------------------
// simple dual-port sample RAM, N_MAX words, registered read
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dft_ram
	import dft_pkg::*;
(
	input logic     clk,
	dft_mem_if.ram  mem
);

	sample_t mem_q [N_MAX];

	// read before write on an address clash, old word comes back
	always_ff @(posedge clk) begin
		if (mem.wr_en) begin
			mem_q[mem.wr_addr] <= mem.wr_data;
		end
		if (mem.rd_en) begin
			mem.rd_data <= mem_q[mem.rd_addr];
		end
	end

endmodule

// ==== hdl/dft_mem_arbiter.sv ====
//--------------------------------------------------------------------------
// hands the single RAM to sink, stage controller or source by phase;
// strobes of the clients that do not own the phase are held off
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dft_mem_arbiter
	import dft_pkg::*;
(
	input logic        clk,
	input phase_e      phase,
	dft_mem_if.ram     sink_mem,
	dft_mem_if.ram     stage_mem,
	dft_mem_if.ram     source_mem,
	dft_mem_if.client  ram_mem
);

	// grant moves only on a clock edge
	phase_e grant;

	always_ff @(posedge clk) begin
		grant <= phase;
	end

	// combinational route, RAM latency unchanged
	always_comb begin
		ram_mem.wr_en = 1'b0;
		ram_mem.wr_addr = '0;
		ram_mem.wr_data = '0;
		ram_mem.rd_en = 1'b0;
		ram_mem.rd_addr = '0;
		case (grant)
			PH_SINK: begin
				ram_mem.wr_en = sink_mem.wr_en;
				ram_mem.wr_addr = sink_mem.wr_addr;
				ram_mem.wr_data = sink_mem.wr_data;
				ram_mem.rd_en = sink_mem.rd_en;
				ram_mem.rd_addr = sink_mem.rd_addr;
			end
			PH_STAGE: begin
				ram_mem.wr_en = stage_mem.wr_en;
				ram_mem.wr_addr = stage_mem.wr_addr;
				ram_mem.wr_data = stage_mem.wr_data;
				ram_mem.rd_en = stage_mem.rd_en;
				ram_mem.rd_addr = stage_mem.rd_addr;
			end
			PH_SOURCE: begin
				ram_mem.wr_en = source_mem.wr_en;
				ram_mem.wr_addr = source_mem.wr_addr;
				ram_mem.wr_data = source_mem.wr_data;
				ram_mem.rd_en = source_mem.rd_en;
				ram_mem.rd_addr = source_mem.rd_addr;
			end
			default: begin
				// idle, RAM untouched
			end
		endcase
	end

	// read data fans out to everyone
	assign sink_mem.rd_data = ram_mem.rd_data;
	assign stage_mem.rd_data = ram_mem.rd_data;
	assign source_mem.rd_data = ram_mem.rd_data;

endmodule

// ==== hdl/dft_sink.sv ====
//--------------------------------------------------------------------------
// input stage; writes each sample at the bit-reversed address of its index
// so the passes run in place, drops the packet on an input gap timeout
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dft_sink
	import dft_pkg::*;
#(
	parameter int SINK_TIMEOUT = 64
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  active,
	input  logic [2:0]            size,
	input  logic                  in_valid,
	input  logic signed [D_W-1:0] in_re,
	input  logic signed [D_W-1:0] in_im,
	dft_mem_if.client             mem,
	output logic                  sink_done,
	output logic                  sink_abort
);

	localparam int G_W = $clog2(SINK_TIMEOUT + 1);

	logic [LOG_N_MAX-1:0] cnt;
	logic [LOG_N_MAX-1:0] last_idx;
	logic [LOG_N_MAX-1:0] rev_full;
	logic [LOG_N_MAX-1:0] rev_addr;
	logic [G_W-1:0]       gap;

	assign last_idx = LOG_N_MAX'((1 << size) - 1);

	// reverse all bits, then drop the unused top ones
	// sop sample is index 0 so a size not yet latched does no harm
	always_comb begin
		for (int i = 0; i < LOG_N_MAX; i++) begin
			rev_full[i] = cnt[LOG_N_MAX-1-i];
		end
		rev_addr = rev_full >> (3'(LOG_N_MAX) - size);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			gap <= '0;
			mem.wr_en <= 1'b0;
			sink_done <= 1'b0;
			sink_abort <= 1'b0;
		end else begin
			mem.wr_en <= active && in_valid;
			sink_done <= active && in_valid && (cnt == last_idx);
			sink_abort <= active && !in_valid && (gap == G_W'(SINK_TIMEOUT - 1));
			if (!active) begin
				cnt <= '0;
				gap <= '0;
			end else if (in_valid) begin
				cnt <= cnt + 1'b1;
				gap <= '0;
			end else begin
				gap <= gap + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		mem.wr_addr <= rev_addr;
		mem.wr_data <= '{re: in_re, im: in_im};
	end

	// write only client
	assign mem.rd_en = 1'b0;
	assign mem.rd_addr = '0;

endmodule

// ==== hdl/dft_stage_ctrl.sv ====
//--------------------------------------------------------------------------
// runs the in-place DIT passes; two reads per butterfly, operands go out
// to the butterfly, results come back two cycles later and are written
// over two cycles; each pass drains before the next one starts
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dft_stage_ctrl
	import dft_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic [2:0] size,
	dft_mem_if.client  mem,
	output logic       bf_valid,
	output sample_t    bf_a,
	output sample_t    bf_b,
	output sample_t    bf_tw,
	input  logic       bf_out_valid,
	input  sample_t    bf_out_a,
	input  sample_t    bf_out_b,
	output logic       stage_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RD_A,
		ST_RD_B,
		ST_DRAIN
	} state_e;

	state_e state;

	logic [2:0]                  pass;
	logic [2:0]                  pass_last;
	logic [LOG_N_MAX-2:0]        bf_cnt;
	logic [LOG_N_MAX-2:0]        bf_last;
	logic [LOG_N_MAX-2:0]        j_idx;
	logic [LOG_N_MAX-2:0]        grp;
	logic [LOG_N_MAX-2:0]        tw_idx;
	logic [LOG_N_MAX-1:0]        top_addr;
	logic [LOG_N_MAX-1:0]        bot_addr;
	logic [2:0][LOG_N_MAX-1:0]   top_pipe;
	logic [2:0][LOG_N_MAX-1:0]   bot_pipe;
	logic                        b_pend;
	logic [LOG_N_MAX-1:0]        b_addr;
	sample_t                     b_data;
	logic [3:0]                  wr_pend;

	assign pass_last = size - 3'd1;
	assign bf_last = (LOG_N_MAX-1)'((1 << (size - 3'd1)) - 1);

	// ----------------------------------------------------------------------
	// butterfly addressing, half span 2^pass
	// ----------------------------------------------------------------------
	always_comb begin
		j_idx = bf_cnt & (LOG_N_MAX-1)'((1 << pass) - 1);
		grp = bf_cnt >> pass;
		top_addr = (LOG_N_MAX'(grp) << (pass + 3'd1)) | LOG_N_MAX'(j_idx);
		bot_addr = top_addr | (LOG_N_MAX'(1) << pass);
		// stride of N_MAX / 2^(pass+1) into the shared table
		tw_idx = j_idx << (3'(LOG_N_MAX - 1) - pass);
	end

	// a then b on back to back cycles
	assign mem.rd_en = (state == ST_RD_A) || (state == ST_RD_B);
	assign mem.rd_addr = (state == ST_RD_A) ? top_addr : bot_addr;

	// b is taken straight off the RAM, one cycle behind a
	assign bf_b = mem.rd_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			pass <= '0;
			bf_cnt <= '0;
			stage_done <= 1'b0;
		end else begin
			stage_done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						pass <= '0;
						bf_cnt <= '0;
						state <= ST_RD_A;
					end
				end
				ST_RD_A: begin
					state <= ST_RD_B;
				end
				ST_RD_B: begin
					bf_cnt <= bf_cnt + 1'b1;
					state <= (bf_cnt == bf_last) ? ST_DRAIN : ST_RD_A;
				end
				ST_DRAIN: begin
					// next pass reads what this one wrote
					if (wr_pend == 4'd0) begin
						bf_cnt <= '0;
						if (pass == pass_last) begin
							stage_done <= 1'b1;
							state <= ST_IDLE;
						end else begin
							pass <= pass + 3'd1;
							state <= ST_RD_A;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// operand launch and address pipe, 3 deep to meet bf_out_valid
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bf_valid <= 1'b0;
		end else begin
			bf_valid <= (state == ST_RD_B);
		end
	end

	always_ff @(posedge clk) begin
		bf_a <= mem.rd_data;
		bf_tw <= TWIDDLE[tw_idx];
		top_pipe <= {top_pipe[1:0], top_addr};
		bot_pipe <= {bot_pipe[1:0], bot_addr};
	end

	// ----------------------------------------------------------------------
	// write back, a first then the held b
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem.wr_en <= 1'b0;
			b_pend <= 1'b0;
			wr_pend <= '0;
		end else begin
			mem.wr_en <= bf_out_valid || b_pend;
			b_pend <= bf_out_valid;
			// two writes owed per issued butterfly
			wr_pend <= wr_pend + ((state == ST_RD_A) ? 4'd2 : 4'd0) - {3'd0, mem.wr_en};
		end
	end

	always_ff @(posedge clk) begin
		if (bf_out_valid) begin
			mem.wr_addr <= top_pipe[2];
			mem.wr_data <= bf_out_a;
			b_addr <= bot_pipe[2];
			b_data <= bf_out_b;
		end else begin
			mem.wr_addr <= b_addr;
			mem.wr_data <= b_data;
		end
	end

endmodule

// ==== hdl/dft_butterfly.sv ====
//--------------------------------------------------------------------------
// radix-2 DIT butterfly, two register stages; a +/- b*w, halved
// results wrap to D_W bits, one operand accepted per cycle
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dft_butterfly
	import dft_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    in_valid,
	input  sample_t a,
	input  sample_t b,
	input  sample_t tw,
	output logic    out_valid,
	output sample_t out_a,
	output sample_t out_b
);

	// product scaled back by 2^15 needs two guard bits
	localparam int P_W = D_W + 2;

	logic signed [2*D_W:0] prod_re;
	logic signed [2*D_W:0] prod_im;
	logic signed [P_W-1:0] p_re;
	logic signed [P_W-1:0] p_im;
	logic signed [P_W:0]   sum_re;
	logic signed [P_W:0]   sum_im;
	logic signed [P_W:0]   dif_re;
	logic signed [P_W:0]   dif_im;
	sample_t               a_q;
	logic                  v_q;

	// full precision b*w
	assign prod_re = $signed(b.re) * $signed(tw.re) - $signed(b.im) * $signed(tw.im);
	assign prod_im = $signed(b.re) * $signed(tw.im) + $signed(b.im) * $signed(tw.re);

	// stage 2 adders from stage 1 registers
	assign sum_re = $signed(a_q.re) + p_re;
	assign sum_im = $signed(a_q.im) + p_im;
	assign dif_re = $signed(a_q.re) - p_re;
	assign dif_im = $signed(a_q.im) - p_im;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v_q <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			v_q <= in_valid;
			out_valid <= v_q;
		end
	end

	always_ff @(posedge clk) begin
		// stage 1, truncating Q1.15 multiply
		p_re <= P_W'(prod_re >>> 15);
		p_im <= P_W'(prod_im >>> 15);
		a_q <= a;
		// stage 2, halve every pass
		out_a.re <= D_W'(sum_re >>> 1);
		out_a.im <= D_W'(sum_im >>> 1);
		out_b.re <= D_W'(dif_re >>> 1);
		out_b.im <= D_W'(dif_im >>> 1);
	end

endmodule

// ==== hdl/dft_source.sv ====
//--------------------------------------------------------------------------
// output stage; reads the result in natural order and frames the stream
// first sample leaves two cycles after start
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dft_source
	import dft_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [2:0]            size,
	dft_mem_if.client             mem,
	output logic                  out_valid,
	output logic                  out_sop,
	output logic                  out_eop,
	output logic signed [D_W-1:0] out_re,
	output logic signed [D_W-1:0] out_im,
	output logic                  source_done
);

	logic                 busy;
	logic [LOG_N_MAX-1:0] cnt;
	logic [LOG_N_MAX-1:0] last_idx;
	logic                 v1;
	logic                 sop1;
	logic                 eop1;

	assign last_idx = LOG_N_MAX'((1 << size) - 1);

	// first read in the start cycle itself
	assign mem.rd_en = start || busy;
	assign mem.rd_addr = cnt;
	assign source_done = mem.rd_en && (cnt == last_idx);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			v1 <= 1'b0;
			sop1 <= 1'b0;
			eop1 <= 1'b0;
			out_valid <= 1'b0;
			out_sop <= 1'b0;
			out_eop <= 1'b0;
		end else begin
			if (mem.rd_en) begin
				cnt <= source_done ? '0 : cnt + 1'b1;
				busy <= !source_done;
			end
			// flags ride along with the RAM latency
			v1 <= mem.rd_en;
			sop1 <= mem.rd_en && (cnt == '0);
			eop1 <= source_done;
			out_valid <= v1;
			out_sop <= sop1;
			out_eop <= eop1;
		end
	end

	always_ff @(posedge clk) begin
		out_re <= mem.rd_data.re;
		out_im <= mem.rd_data.im;
	end

	// read only client
	assign mem.wr_en = 1'b0;
	assign mem.wr_addr = '0;
	assign mem.wr_data = '0;

endmodule

// ==== hdl/dft_mem_top.sv ====
//--------------------------------------------------------------------------
// DFT engine top; phase sequencer IDLE -> SINK -> STAGE -> SOURCE around
// one shared sample RAM, plain streaming ports, no back-pressure
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dft_mem_top
	import dft_pkg::*;
#(
	parameter int SINK_TIMEOUT = 64
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic                  in_sop,
	input  logic [2:0]            in_size,
	input  logic signed [D_W-1:0] in_re,
	input  logic signed [D_W-1:0] in_im,
	output logic                  sink_ready,
	output logic                  out_valid,
	output logic                  out_sop,
	output logic                  out_eop,
	output logic signed [D_W-1:0] out_re,
	output logic signed [D_W-1:0] out_im
);

	phase_e     phase;
	phase_e     phase_nxt;
	logic [2:0] size_q;
	logic [2:0] sink_size;
	logic       sop_ok;
	logic       sink_done;
	logic       sink_abort;
	logic       stage_start;
	logic       stage_done;
	logic       source_start;
	logic       source_done;
	logic       bf_valid;
	logic       bf_out_valid;
	sample_t    bf_a;
	sample_t    bf_b;
	sample_t    bf_tw;
	sample_t    bf_out_a;
	sample_t    bf_out_b;

	dft_mem_if sink_mem ();
	dft_mem_if stage_mem ();
	dft_mem_if source_mem ();
	dft_mem_if ram_mem ();

	// ----------------------------------------------------------------------
	// phase sequencer
	// ----------------------------------------------------------------------
	// sizes 0, 6 and 7 are not a packet
	assign sop_ok = sink_ready && in_valid && in_sop
		&& (in_size != 3'd0) && (in_size <= 3'(LOG_N_MAX));

	always_comb begin
		phase_nxt = phase;
		case (phase)
			PH_IDLE: if (sop_ok) phase_nxt = PH_SINK;
			PH_SINK: begin
				if (sink_abort) begin
					phase_nxt = PH_IDLE;
				end else if (sink_done) begin
					phase_nxt = PH_STAGE;
				end
			end
			PH_STAGE: if (stage_done) phase_nxt = PH_SOURCE;
			PH_SOURCE: if (source_done) phase_nxt = PH_IDLE;
			default: phase_nxt = PH_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			size_q <= '0;
			sink_ready <= 1'b0;
			stage_start <= 1'b0;
			source_start <= 1'b0;
		end else begin
			phase <= phase_nxt;
			if (sop_ok) begin
				size_q <= in_size;
			end
			// drops right after an accepted sop
			sink_ready <= (phase == PH_IDLE) && !sop_ok;
			// one cycle strobes in the first cycle of a phase
			stage_start <= (phase == PH_SINK) && (phase_nxt == PH_STAGE);
			source_start <= (phase == PH_STAGE) && (phase_nxt == PH_SOURCE);
		end
	end

	// size_q loads at the sop edge, so the sop cycle takes in_size directly
	assign sink_size = sop_ok ? in_size : size_q;

	// ----------------------------------------------------------------------
	// datapath
	// ----------------------------------------------------------------------
	// sink sees the sop sample while still in IDLE
	dft_sink #(
		.SINK_TIMEOUT(SINK_TIMEOUT)
	) i_sink (
		.clk        (clk),
		.rst_n      (rst_n),
		.active     (phase_nxt == PH_SINK),
		.size       (sink_size),
		.in_valid   (in_valid),
		.in_re      (in_re),
		.in_im      (in_im),
		.mem        (sink_mem.client),
		.sink_done  (sink_done),
		.sink_abort (sink_abort)
	);

	dft_stage_ctrl i_stage_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (stage_start),
		.size         (size_q),
		.mem          (stage_mem.client),
		.bf_valid     (bf_valid),
		.bf_a         (bf_a),
		.bf_b         (bf_b),
		.bf_tw        (bf_tw),
		.bf_out_valid (bf_out_valid),
		.bf_out_a     (bf_out_a),
		.bf_out_b     (bf_out_b),
		.stage_done   (stage_done)
	);

	dft_butterfly i_butterfly (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (bf_valid),
		.a         (bf_a),
		.b         (bf_b),
		.tw        (bf_tw),
		.out_valid (bf_out_valid),
		.out_a     (bf_out_a),
		.out_b     (bf_out_b)
	);

	dft_source i_source (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (source_start),
		.size        (size_q),
		.mem         (source_mem.client),
		.out_valid   (out_valid),
		.out_sop     (out_sop),
		.out_eop     (out_eop),
		.out_re      (out_re),
		.out_im      (out_im),
		.source_done (source_done)
	);

	// next phase in, so the grant equals the phase register
	dft_mem_arbiter i_arbiter (
		.clk        (clk),
		.phase      (phase_nxt),
		.sink_mem   (sink_mem.ram),
		.stage_mem  (stage_mem.ram),
		.source_mem (source_mem.ram),
		.ram_mem    (ram_mem.client)
	);

	dft_ram i_ram (
		.clk (clk),
		.mem (ram_mem.ram)
	);

endmodule

// ==== dv/dft_ref_model.svh ====
//--------------------------------------------------------------------------
// bit-exact reference for the radix-2 engine; bit-reversed load, then DIT
// passes with a truncating Q1.15 multiply and a halving butterfly
// included inside the testbench module, after the dft_pkg import
//--------------------------------------------------------------------------
`ifndef DFT_REF_MODEL_SVH
`define DFT_REF_MODEL_SVH

	// low D_W bits only, same as a D_W wide register
	function automatic logic signed [D_W-1:0] wrap_part(input longint v);
		return v[D_W-1:0];
	endfunction

	// index reversed within the given number of bits
	function automatic int reverse_index(input int idx, input int bits);
		int r;
		int k;
		r = 0;
		for (k = 0; k < bits; k++) begin
			r = (r << 1) | ((idx >> k) & 1);
		end
		return r;
	endfunction

	// a + b*w and a - b*w, each halved
	task automatic ref_butterfly(input sample_t a, input sample_t b, input sample_t w,
			output sample_t oa, output sample_t ob);
		longint p_re;
		longint p_im;
		// product back to Q1.15, floor on the shift
		p_re = (longint'($signed(b.re)) * longint'($signed(w.re))
			- longint'($signed(b.im)) * longint'($signed(w.im))) >>> 15;
		p_im = (longint'($signed(b.re)) * longint'($signed(w.im))
			+ longint'($signed(b.im)) * longint'($signed(w.re))) >>> 15;
		oa.re = wrap_part((longint'($signed(a.re)) + p_re) >>> 1);
		oa.im = wrap_part((longint'($signed(a.im)) + p_im) >>> 1);
		ob.re = wrap_part((longint'($signed(a.re)) - p_re) >>> 1);
		ob.im = wrap_part((longint'($signed(a.im)) - p_im) >>> 1);
	endtask

	// full transform of 2^size points, natural order in and out
	task automatic ref_dft(input int size, input sample_t x [N_MAX], output sample_t y [N_MAX]);
		sample_t m [N_MAX];
		sample_t ra;
		sample_t rb;
		int n;
		int half;
		int s;
		int g;
		int j;
		int i;
		n = 1 << size;
		for (i = 0; i < N_MAX; i++) begin
			m[i] = '0;
		end
		for (i = 0; i < n; i++) begin
			m[reverse_index(i, size)] = x[i];
		end
		for (s = 0; s < size; s++) begin
			half = 1 << s;
			for (g = 0; g < n; g += 2 * half) begin
				for (j = 0; j < half; j++) begin
					// twiddle W_(2*half)^j from the N_MAX table
					ref_butterfly(m[g + j], m[g + j + half],
						TWIDDLE[j << (LOG_N_MAX - s - 1)], ra, rb);
					m[g + j] = ra;
					m[g + j + half] = rb;
				end
			end
		end
		y = m;
	endtask

`endif

// ==== dv/tb_dft_mem.sv ====
//--------------------------------------------------------------------------
// testbench for the single-RAM DFT engine; impulse, random, ignored input,
// bad size, gap timeout and back-to-back packets, all checked bit-exact
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_dft_mem
	import dft_pkg::*;
();

	localparam int SINK_TIMEOUT = 64;
	localparam int WAIT_LIMIT = 2000;

	logic                  clk;
	logic                  rst_n;
	logic                  in_valid;
	logic                  in_sop;
	logic [2:0]            in_size;
	logic signed [D_W-1:0] in_re;
	logic signed [D_W-1:0] in_im;
	logic                  sink_ready;
	logic                  out_valid;
	logic                  out_sop;
	logic                  out_eop;
	logic signed [D_W-1:0] out_re;
	logic signed [D_W-1:0] out_im;

	// stimulus state and expected output
	logic [31:0] lfsr;
	logic        quiet;
	sample_t     exp_q [$];
	int          len_q [$];
	int          cur_len;
	int          out_cnt;

	`include "dft_ref_model.svh"

	dft_mem_top #(
		.SINK_TIMEOUT(SINK_TIMEOUT)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sop     (in_sop),
		.in_size    (in_size),
		.in_re      (in_re),
		.in_im      (in_im),
		.sink_ready (sink_ready),
		.out_valid  (out_valid),
		.out_sop    (out_sop),
		.out_eop    (out_eop),
		.out_re     (out_re),
		.out_im     (out_im)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit
	task automatic draw_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_part(input string name, input logic signed [D_W-1:0] exp_v,
			input logic signed [D_W-1:0] got);
		assert (got === exp_v) else
			abort_run($sformatf("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_v, got));
	endtask

	// returns on the edge where sink_ready was seen high
	task automatic wait_ready(input int limit);
		int n;
		n = 0;
		@(posedge clk);
		while (sink_ready !== 1'b1) begin
			n++;
			if (n > limit) abort_run("sink_ready did not rise in time");
			@(posedge clk);
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 || len_q.size() != 0) begin
			@(posedge clk);
			n++;
			if (n > limit) abort_run("expected output did not arrive in time");
		end
	endtask

	// first cnt samples of x, sop on the first, valid on consecutive cycles
	task automatic drive_samples(input int size, input int cnt, input sample_t x [N_MAX]);
		int i;
		for (i = 0; i < cnt; i++) begin
			if (i > 0) @(posedge clk);
			in_valid <= 1'b1;
			in_sop <= (i == 0);
			in_size <= 3'(size);
			in_re <= x[i].re;
			in_im <= x[i].im;
		end
		@(posedge clk);
		in_valid <= 1'b0;
		in_sop <= 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// packet scenarios
	// ----------------------------------------------------------------------
	task automatic run_random(input int size);
		sample_t x [N_MAX];
		sample_t y [N_MAX];
		logic [31:0] r;
		int i;
		for (i = 0; i < N_MAX; i++) begin
			x[i] = '0;
		end
		for (i = 0; i < (1 << size); i++) begin
			draw_bits(32, r);
			x[i] = r;
		end
		ref_dft(size, x, y);
		for (i = 0; i < (1 << size); i++) begin
			exp_q.push_back(y[i]);
		end
		len_q.push_back(1 << size);
		wait_ready(WAIT_LIMIT);
		drive_samples(size, 1 << size, x);
	endtask

	// impulse at index 0, every bin is the impulse shifted right by size
	task automatic run_impulse(input int size);
		sample_t x [N_MAX];
		sample_t e;
		logic [31:0] r;
		int i;
		for (i = 0; i < N_MAX; i++) begin
			x[i] = '0;
		end
		draw_bits(32, r);
		x[0] = r;
		e.re = x[0].re >>> size;
		e.im = x[0].im >>> size;
		for (i = 0; i < (1 << size); i++) begin
			exp_q.push_back(e);
		end
		len_q.push_back(1 << size);
		wait_ready(WAIT_LIMIT);
		drive_samples(size, 1 << size, x);
	endtask

	// junk right after a full size packet, engine still busy
	task automatic run_ignored_inputs();
		logic [31:0] r;
		int i;
		for (i = 0; i < 20; i++) begin
			assert (sink_ready === 1'b0) else
				abort_run("sink_ready high while a packet was in flight");
			draw_bits(32, r);
			in_valid <= 1'b1;
			in_sop <= r[0];
			in_size <= 3'd5;
			in_re <= r[31:16];
			in_im <= r[15:0];
			@(posedge clk);
		end
		in_valid <= 1'b0;
		in_sop <= 1'b0;
	endtask

	// sop with size 0, 6 and 7, none of them a packet
	task automatic run_bad_sizes();
		int i;
		for (i = 0; i < 3; i++) begin
			wait_ready(WAIT_LIMIT);
			in_valid <= 1'b1;
			in_sop <= 1'b1;
			in_size <= (i == 0) ? 3'd0 : 3'(5 + i);
			@(posedge clk);
			in_valid <= 1'b0;
			in_sop <= 1'b0;
		end
	endtask

	// half a packet, then silence until the gap counter drops it
	task automatic run_abort(input int size);
		sample_t x [N_MAX];
		logic [31:0] r;
		int i;
		int n;
		for (i = 0; i < N_MAX; i++) begin
			draw_bits(32, r);
			x[i] = r;
		end
		wait_ready(WAIT_LIMIT);
		quiet <= 1'b1;
		drive_samples(size, 1 << (size - 1), x);
		n = 0;
		@(posedge clk);
		while (sink_ready !== 1'b1) begin
			n++;
			if (n > SINK_TIMEOUT + 16) abort_run("sink_ready did not return after an input gap");
			@(posedge clk);
		end
		n = 0;
		while (n < 16) begin
			@(posedge clk);
			n++;
		end
		quiet <= 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// output capture and checks
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		sample_t e;
		if (rst_n && out_valid) begin
			if (out_sop) begin
				if (len_q.size() == 0) abort_run("output packet started with none expected");
				cur_len = len_q.pop_front();
				out_cnt = 0;
			end
			if (exp_q.size() == 0) abort_run("output sample arrived with none expected");
			e = exp_q.pop_front();
			check_part("out_re", e.re, out_re);
			check_part("out_im", e.im, out_im);
			out_cnt++;
			if (out_eop) begin
				assert (out_cnt == cur_len) else
					abort_run($sformatf("[FAIL] %0t out_valid run expected %0d got %0d",
						$time, cur_len, out_cnt));
			end
		end
	end

	// outputs quiet in reset and in the first cycle after it
	a_reset_low: assert property (@(posedge clk)
		!rst_n |=> (!sink_ready && !out_valid && !out_sop && !out_eop))
		else abort_run("outputs active during reset");

	a_flags_in_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(out_sop || out_eop) |-> out_valid)
		else abort_run("out_sop or out_eop high without out_valid");

	a_sop_first: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !$past(out_valid)) |-> out_sop)
		else abort_run("output burst started without out_sop");

	a_valid_run: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_eop) |=> out_valid)
		else abort_run("out_valid dropped inside a packet");

	a_eop_last: assert property (@(posedge clk) disable iff (!rst_n)
		out_eop |=> !out_valid)
		else abort_run("out_valid stayed high after out_eop");

	a_bad_size: assert property (@(posedge clk) disable iff (!rst_n)
		(sink_ready && in_valid && in_sop && (in_size == 3'd0 || in_size > 3'd5)) |=> sink_ready)
		else abort_run("sink_ready dropped after a sop with an invalid size");

	a_no_output: assert property (@(posedge clk) disable iff (!rst_n)
		quiet |-> !out_valid)
		else abort_run("output produced for a packet that timed out");

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		logic [31:0] r;
		int sz;
		int k;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_sop = 1'b0;
		in_size = 3'd0;
		in_re = '0;
		in_im = '0;
		lfsr = 32'h2ce4_66d9;
		quiet = 1'b0;
		cur_len = 0;
		out_cnt = 0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		// every size, random then impulse
		for (sz = 1; sz <= LOG_N_MAX; sz++) begin
			run_random(sz);
			run_impulse(sz);
		end
		for (k = 0; k < 3; k++) begin
			run_random(LOG_N_MAX);
		end
		// inputs while busy must not disturb the next packet
		run_random(LOG_N_MAX);
		run_ignored_inputs();
		run_random(LOG_N_MAX);
		run_bad_sizes();
		run_random(3);
		run_abort(LOG_N_MAX);
		run_random(LOG_N_MAX);
		// back to back, random sizes
		for (k = 0; k < 6; k++) begin
			draw_bits(3, r);
			run_random(1 + int'(r) % LOG_N_MAX);
		end
		wait_drained(WAIT_LIMIT);
		if (exp_q.size() == 0 && len_q.size() == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			abort_run("expected output still outstanding at the end");
		end
	end

endmodule

// ==== build.f ====
+incdir+dv
hdl/dft_pkg.sv
hdl/dft_mem_if.sv
hdl/dft_ram.sv
hdl/dft_mem_arbiter.sv
hdl/dft_sink.sv
hdl/dft_stage_ctrl.sv
hdl/dft_butterfly.sv
hdl/dft_source.sv
hdl/dft_mem_top.sv
dv/tb_dft_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_dft_mem
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
